// ==== source/retire_mon_pkg.sv ====
`default_nettype none

package retire_mon_pkg;

    // data path widths
    localparam int xlen = 32;
    localparam int count_width = 32;
    localparam int warn_width = 8;
    localparam int fault_width = 3;

    typedef logic [xlen-1:0] inst_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [xlen-1:0] order_t;
    typedef logic [count_width-1:0] count_t;
    typedef logic [warn_width-1:0] warn_t;
    typedef logic [fault_width-1:0] fault_t;

    // fault flag positions
    localparam int order_gap_bit = 0;
    localparam int pc_break_bit = 1;
    localparam int mismatch_bit = 2;

    // marker instructions encoded as slti x0 variants
    localparam inst_t seg_start_inst = 32'h0010_2013;
    localparam inst_t seg_stop_inst = 32'h0020_2013;
    localparam inst_t mismatch_inst = 32'hFF60_2013;
    localparam inst_t warn_inst = 32'hFF50_2013;
    localparam inst_t halt_inst = 32'hF000_2013;

    // beq x0, x0, 0 and jal x0, 0
    localparam inst_t branch_loop_inst = 32'h0000_0063;
    localparam inst_t jump_loop_inst = 32'h0000_006F;

    typedef enum logic [1:0] {
        seg_idle,
        seg_run,
        seg_report,
        seg_halt
    } seg_state_t;

endpackage

`default_nettype wire

// ==== source/monitor_ifs.sv ====
`default_nettype none

interface retire_if;
    import retire_mon_pkg::*;

    logic valid;
    order_t order;
    inst_t inst;
    addr_t pc_rdata;
    addr_t pc_wdata;

    modport sink (input valid, order, inst, pc_rdata, pc_wdata);
    modport source (output valid, order, inst, pc_rdata, pc_wdata);
endinterface

interface commit_event_if;
    logic ev_valid;
    logic ev_start;
    logic ev_stop;
    logic ev_halt;
    logic ev_mismatch;
    logic ev_warn;

    modport producer (output ev_valid, ev_start, ev_stop, ev_halt, ev_mismatch, ev_warn);
    modport consumer (input ev_valid, ev_start, ev_stop, ev_halt, ev_mismatch, ev_warn);
endinterface

`default_nettype wire

// ==== source/commit_classifier.sv ====
`default_nettype none

module commit_classifier (
    input wire logic itf,
    input wire logic reset,
    retire_if.sink rt,
    commit_event_if.producer ev
);
    import retire_mon_pkg::*;

    logic is_start;
    logic is_stop;
    logic is_mismatch;
    logic is_warn;
    logic is_halt;

    // marker decode on the raw commit
    always_comb begin
        is_start = (rt.inst == seg_start_inst);
        is_stop = (rt.inst == seg_stop_inst);
        is_mismatch = (rt.inst == mismatch_inst);
        is_warn = (rt.inst == warn_inst);
        // halt marker or a core spinning on itself
        is_halt = (rt.inst == halt_inst)
            || (rt.inst == branch_loop_inst)
            || (rt.inst == jump_loop_inst)
            || (rt.pc_rdata == rt.pc_wdata);
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            ev.ev_valid <= 1'b0;
            ev.ev_start <= 1'b0;
            ev.ev_stop <= 1'b0;
            ev.ev_halt <= 1'b0;
            ev.ev_mismatch <= 1'b0;
            ev.ev_warn <= 1'b0;
        end else begin
            ev.ev_valid <= rt.valid;
            ev.ev_start <= rt.valid && is_start;
            ev.ev_stop <= rt.valid && is_stop;
            ev.ev_halt <= rt.valid && is_halt;
            ev.ev_mismatch <= rt.valid && is_mismatch;
            ev.ev_warn <= rt.valid && is_warn;
        end
    end

endmodule

`default_nettype wire

// ==== source/commit_checker.sv ====
`default_nettype none

module commit_checker (
    input wire logic itf,
    input wire logic reset,
    retire_if.sink rt,
    commit_event_if.consumer ev,
    input wire logic halted,
    output retire_mon_pkg::fault_t fault
);
    import retire_mon_pkg::*;

    order_t prev_order;
    addr_t prev_pc;
    logic baseline;
    logic frozen;
    logic order_gap;
    logic pc_break;

    // event register still shows the halt commit one cycle before halted rises
    assign frozen = halted || (ev.ev_valid && ev.ev_halt);

    assign order_gap = (rt.order != order_t'(prev_order + 1'b1));
    assign pc_break = (rt.pc_rdata != prev_pc);

    always_ff @(posedge itf) begin
        if (reset) begin
            baseline <= 1'b0;
        end else if (rt.valid && !frozen) begin
            baseline <= 1'b1;
        end
    end

    // previous commit is only meaningful once baseline is set
    always_ff @(posedge itf) begin
        if (rt.valid && !frozen) begin
            prev_order <= rt.order;
            prev_pc <= rt.pc_wdata;
        end
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            fault <= '0;
        end else if (!frozen) begin
            if (rt.valid && baseline && order_gap) begin
                fault[order_gap_bit] <= 1'b1;
            end
            if (rt.valid && baseline && pc_break) begin
                fault[pc_break_bit] <= 1'b1;
            end
            if (ev.ev_valid && ev.ev_mismatch) begin
                fault[mismatch_bit] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/segment_fsm.sv ====
`default_nettype none

module segment_fsm (
    input wire logic itf,
    input wire logic reset,
    commit_event_if.consumer ev,
    input wire logic busy,
    output logic clear_counts,
    output logic counting,
    output logic load_report,
    output logic halted
);
    import retire_mon_pkg::*;

    seg_state_t state;
    logic start_seen;
    logic stop_seen;
    logic halt_seen;

    assign halt_seen = ev.ev_valid && ev.ev_halt;
    // halt wins over any marker on the same commit
    assign start_seen = ev.ev_valid && ev.ev_start && !halt_seen;
    assign stop_seen = ev.ev_valid && ev.ev_stop && !halt_seen;

    always_ff @(posedge itf) begin
        if (reset) begin
            state <= seg_idle;
            load_report <= 1'b0;
        end else begin
            load_report <= 1'b0;
            if (halt_seen) begin
                state <= seg_halt;
            end else begin
                unique case (state)
                    seg_idle: begin
                        if (start_seen) begin
                            state <= seg_run;
                        end
                    end
                    seg_run: begin
                        // a second start just restarts the segment
                        if (stop_seen) begin
                            state <= seg_report;
                            load_report <= 1'b1;
                        end
                    end
                    seg_report: begin
                        // markers ignored until the result is taken
                        if (!busy) begin
                            state <= seg_idle;
                        end
                    end
                    seg_halt: begin
                        state <= seg_halt;
                    end
                    default: begin
                        state <= seg_idle;
                    end
                endcase
            end
        end
    end

    assign clear_counts = start_seen && ((state == seg_idle) || (state == seg_run));
    assign counting = (state == seg_run);
    assign halted = (state == seg_halt);

endmodule

`default_nettype wire

// ==== source/segment_counters.sv ====
`default_nettype none

module segment_counters (
    input wire logic itf,
    input wire logic reset,
    commit_event_if.consumer ev,
    input wire logic clear_counts,
    input wire logic counting,
    input wire logic halted,
    output retire_mon_pkg::count_t inst_count,
    output retire_mon_pkg::count_t cycle_count,
    output retire_mon_pkg::warn_t warn_count
);

    logic warn_hit;

    // halt commit carries no warning
    assign warn_hit = ev.ev_valid && ev.ev_warn && !ev.ev_halt && !halted;

    always_ff @(posedge itf) begin
        if (reset) begin
            inst_count <= '0;
            cycle_count <= '0;
        end else if (clear_counts) begin
            inst_count <= '0;
            cycle_count <= '0;
        end else if (counting) begin
            // both counts wrap
            cycle_count <= cycle_count + 1'b1;
            if (ev.ev_valid && !ev.ev_start) begin
                inst_count <= inst_count + 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            warn_count <= '0;
        end else if (warn_hit && !(&warn_count)) begin
            // saturate at all ones
            warn_count <= warn_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/report_port.sv ====
`default_nettype none

module report_port (
    input wire logic itf,
    input wire logic reset,
    input wire logic load_report,
    input retire_mon_pkg::count_t inst_count,
    input retire_mon_pkg::count_t cycle_count,
    output logic busy,
    output logic report_req,
    input wire logic report_ack,
    output retire_mon_pkg::count_t report_insts,
    output retire_mon_pkg::count_t report_cycles
);

    typedef enum logic [1:0] {
        idle,
        req_high,
        wait_ack_low
    } port_state_t;

    port_state_t state;

    always_ff @(posedge itf) begin
        if (reset) begin
            state <= idle;
        end else begin
            unique case (state)
                idle: begin
                    if (load_report) begin
                        state <= req_high;
                    end
                end
                req_high: begin
                    if (report_ack) begin
                        state <= wait_ack_low;
                    end
                end
                wait_ack_low: begin
                    // four-phase return to zero
                    if (!report_ack) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // result registers held while req is up
    always_ff @(posedge itf) begin
        if ((state == idle) && load_report) begin
            report_insts <= inst_count;
            report_cycles <= cycle_count;
        end
    end

    assign report_req = (state == req_high);
    // load_report covers the cycle before req rises
    assign busy = (state != idle) || load_report;

endmodule

`default_nettype wire

// ==== source/retire_monitor_top.sv ====
`default_nettype none

module retire_monitor_top (
    input wire logic itf,
    input wire logic reset,
    input wire logic commit_valid,
    input retire_mon_pkg::order_t commit_order,
    input retire_mon_pkg::inst_t commit_inst,
    input retire_mon_pkg::addr_t commit_pc_rdata,
    input retire_mon_pkg::addr_t commit_pc_wdata,
    input wire logic report_ack,
    output logic halt,
    output retire_mon_pkg::fault_t fault,
    output retire_mon_pkg::warn_t warn_count,
    output logic report_req,
    output retire_mon_pkg::count_t report_insts,
    output retire_mon_pkg::count_t report_cycles
);
    import retire_mon_pkg::*;

    logic clear_counts;
    logic counting;
    logic load_report;
    logic halted;
    logic busy;
    count_t inst_count;
    count_t cycle_count;

    retire_if rt ();
    commit_event_if ev ();

    assign rt.valid = commit_valid;
    assign rt.order = commit_order;
    assign rt.inst = commit_inst;
    assign rt.pc_rdata = commit_pc_rdata;
    assign rt.pc_wdata = commit_pc_wdata;

    assign halt = halted;

    commit_classifier u_classifier (
        .itf(itf), .reset(reset), .rt(rt.sink), .ev(ev.producer)
    );

    commit_checker u_checker (
        .itf(itf), .reset(reset), .rt(rt.sink), .ev(ev.consumer),
        .halted(halted), .fault(fault)
    );

    segment_fsm u_fsm (
        .itf(itf), .reset(reset), .ev(ev.consumer), .busy(busy),
        .clear_counts(clear_counts), .counting(counting),
        .load_report(load_report), .halted(halted)
    );

    segment_counters u_counters (
        .itf(itf), .reset(reset), .ev(ev.consumer),
        .clear_counts(clear_counts), .counting(counting), .halted(halted),
        .inst_count(inst_count), .cycle_count(cycle_count), .warn_count(warn_count)
    );

    report_port u_report (
        .itf(itf), .reset(reset), .load_report(load_report),
        .inst_count(inst_count), .cycle_count(cycle_count), .busy(busy),
        .report_req(report_req), .report_ack(report_ack),
        .report_insts(report_insts), .report_cycles(report_cycles)
    );

endmodule

`default_nettype wire

// ==== verif/retire_monitor_properties.sv ====
`default_nettype none

module retire_monitor_properties (
    input wire logic itf,
    input wire logic reset,
    input wire logic report_req,
    input wire logic report_ack,
    input retire_mon_pkg::count_t report_insts,
    input retire_mon_pkg::count_t report_cycles,
    input retire_mon_pkg::fault_t fault,
    input wire logic halted
);

    req_held_until_ack: assert property (@(posedge itf) disable iff (reset)
        report_req && !report_ack |=> report_req)
        else $error("report_req dropped before ack");

    data_stable_during_req: assert property (@(posedge itf) disable iff (reset)
        report_req |=> !report_req || ($stable(report_insts) && $stable(report_cycles)))
        else $error("report data changed while req high");

    // a set fault bit may only clear by reset
    fault_sticky: assert property (@(posedge itf) disable iff (reset)
        (|fault) |=> ((fault & $past(fault)) == $past(fault)))
        else $error("fault bit cleared without reset");

    halt_sticky: assert property (@(posedge itf) disable iff (reset)
        halted |=> halted)
        else $error("halt dropped without reset");

endmodule

bind report_port retire_monitor_properties report_props (
    .itf(itf), .reset(reset), .report_req(report_req), .report_ack(report_ack),
    .report_insts(report_insts), .report_cycles(report_cycles),
    .fault(3'b000), .halted(1'b0)
);

bind commit_checker retire_monitor_properties checker_props (
    .itf(itf), .reset(reset), .report_req(1'b0), .report_ack(1'b0),
    .report_insts(32'd0), .report_cycles(32'd0), .fault(fault), .halted(halted)
);

`default_nettype wire

// ==== verif/retire_monitor_scoreboard.sv ====
`default_nettype none

module retire_monitor_scoreboard (
    input wire logic itf,
    input wire logic reset,
    input wire logic commit_valid,
    input retire_mon_pkg::order_t commit_order,
    input retire_mon_pkg::inst_t commit_inst,
    input retire_mon_pkg::addr_t commit_pc_rdata,
    input retire_mon_pkg::addr_t commit_pc_wdata,
    input wire logic report_ack,
    input wire logic halt,
    input retire_mon_pkg::fault_t fault,
    input retire_mon_pkg::warn_t warn_count,
    input wire logic report_req,
    input retire_mon_pkg::count_t report_insts,
    input retire_mon_pkg::count_t report_cycles,
    input wire logic check_stb,
    input int check_id,
    output int errors,
    output int tests
);
    import retire_mon_pkg::*;

    // model segment state is 0 idle, 1 running or 2 report pending
    int seg_state;
    int cycle_no;
    int seg_start;
    int test_errors;
    count_t seg_insts;
    count_t exp_insts_q[$];
    count_t exp_cycles_q[$];
    logic baseline;
    logic saw_req;
    logic prev_req;
    logic exp_halt;
    order_t prev_order;
    addr_t prev_pc;
    fault_t exp_fault;
    warn_t exp_warn;

    initial begin
        errors = 0;
        tests = 0;
        test_errors = 0;
        cycle_no = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "segment";
            2: return "backpressure";
            3: return "faults";
            4: return "markers";
            5: return "halt_marker";
            6: return "halt_selfloop";
            default: return "halt_branch";
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: %s expected %0h actual %0h",
                     test_name(check_id), what, exp, act);
            test_errors++;
        end
    endtask

    task automatic model_commit;
        if (baseline && commit_order != prev_order + 1'b1) begin
            exp_fault[order_gap_bit] = 1'b1;
        end
        if (baseline && commit_pc_rdata != prev_pc) begin
            exp_fault[pc_break_bit] = 1'b1;
        end
        baseline = 1'b1;
        prev_order = commit_order;
        prev_pc = commit_pc_wdata;
        if (commit_inst == halt_inst || commit_inst == branch_loop_inst
            || commit_inst == jump_loop_inst || commit_pc_rdata == commit_pc_wdata) begin
            exp_halt = 1'b1;
        end else begin
            if (commit_inst == mismatch_inst) begin
                exp_fault[mismatch_bit] = 1'b1;
            end
            if (commit_inst == warn_inst && exp_warn != 8'hFF) begin
                exp_warn = exp_warn + 1'b1;
            end
            if (commit_inst == seg_start_inst) begin
                if (seg_state != 2) begin
                    seg_state = 1;
                    seg_start = cycle_no;
                    seg_insts = '0;
                end
            end else if (seg_state == 1) begin
                // every other commit counts including the stop commit
                seg_insts = seg_insts + 1'b1;
                if (commit_inst == seg_stop_inst) begin
                    exp_insts_q.push_back(seg_insts);
                    exp_cycles_q.push_back(count_t'(cycle_no - seg_start));
                    seg_state = 2;
                end
            end
        end
    endtask

    task automatic finish_test;
        compare("fault", 32'(exp_fault), 32'(fault));
        compare("warn_count", 32'(exp_warn), 32'(warn_count));
        compare("halt", 32'(exp_halt), 32'(halt));
        if (exp_insts_q.size() != 0) begin
            $display("%s: an expected segment report never arrived", test_name(check_id));
            test_errors++;
        end
        $display("test %s: %s", test_name(check_id), (test_errors == 0) ? "passed" : "failed");
        errors = errors + test_errors;
        tests++;
        test_errors = 0;
    endtask

    always @(posedge itf) begin
        cycle_no++;
        if (reset) begin
            seg_state = 0;
            baseline = 1'b0;
            saw_req = 1'b0;
            prev_req = 1'b0;
            exp_halt = 1'b0;
            exp_fault = '0;
            exp_warn = '0;
            exp_insts_q.delete();
            exp_cycles_q.delete();
        end else begin
            if (report_req && !prev_req) begin
                if (exp_insts_q.size() == 0) begin
                    $display("%s: report request with no finished segment", test_name(check_id));
                    test_errors++;
                end else begin
                    compare("report_insts", exp_insts_q.pop_front(), report_insts);
                    compare("report_cycles", exp_cycles_q.pop_front(), report_cycles);
                end
            end
            saw_req = saw_req || report_req;
            prev_req = report_req;
            if (commit_valid && !exp_halt) begin
                model_commit();
            end
            // a commit on the edge the port goes idle still finds the fsm in seg_report
            if (seg_state == 2 && saw_req && !report_req && !report_ack) begin
                seg_state = 0;
                saw_req = 1'b0;
            end
            if (check_stb) begin
                finish_test();
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/retire_monitor_tb.sv ====
`default_nettype none

module retire_monitor_tb;
    import retire_mon_pkg::*;

    localparam int k_commit = 0;
    localparam int k_sync = 1;
    localparam int k_end = 2;
    localparam inst_t nop_inst = 32'h0000_0013;

    // pcrel 0 keeps the chain, 1 breaks it and 2 is a self loop
    typedef struct {
        int id;
        int kind;
        inst_t inst;
        int ostep;
        int pcrel;
        int rep;
        int ack_delay;
    } row_t;

    logic itf;
    logic reset;
    logic commit_valid;
    order_t commit_order;
    inst_t commit_inst;
    addr_t commit_pc_rdata;
    addr_t commit_pc_wdata;
    logic report_ack;
    logic halt;
    fault_t fault;
    warn_t warn_count;
    logic report_req;
    count_t report_insts;
    count_t report_cycles;
    logic check_stb;
    int check_id;
    int sb_errors;
    int sb_tests;

    row_t rows[$];
    logic [7:0] lfsr_state;
    int tb_errors;
    int acks_open;
    order_t next_order;
    addr_t next_pc;

    always #50 itf = ~itf;

    retire_monitor_top UUT (
        .itf(itf), .reset(reset), .commit_valid(commit_valid),
        .commit_order(commit_order), .commit_inst(commit_inst),
        .commit_pc_rdata(commit_pc_rdata), .commit_pc_wdata(commit_pc_wdata),
        .report_ack(report_ack), .halt(halt), .fault(fault), .warn_count(warn_count),
        .report_req(report_req), .report_insts(report_insts), .report_cycles(report_cycles)
    );

    retire_monitor_scoreboard scoreboard (
        .itf(itf), .reset(reset), .commit_valid(commit_valid),
        .commit_order(commit_order), .commit_inst(commit_inst),
        .commit_pc_rdata(commit_pc_rdata), .commit_pc_wdata(commit_pc_wdata),
        .report_ack(report_ack), .halt(halt), .fault(fault), .warn_count(warn_count),
        .report_req(report_req), .report_insts(report_insts), .report_cycles(report_cycles),
        .check_stb(check_stb), .check_id(check_id), .errors(sb_errors), .tests(sb_tests)
    );

    // galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic add_row(input int id, input int kind, input inst_t inst,
                           input int ostep, input int pcrel, input int rep, input int ack_delay);
        row_t r;
        r = '{id, kind, inst, ostep, pcrel, rep, ack_delay};
        rows.push_back(r);
    endtask

    task automatic add_commit(input int id, input inst_t inst, input int rep);
        add_row(id, k_commit, inst, 1, 0, rep, -1);
    endtask

    task automatic build_table;
        // 1 segment measurement
        add_commit(1, nop_inst, 3);
        add_commit(1, seg_start_inst, 1);
        add_commit(1, nop_inst, 6);
        add_row(1, k_commit, seg_stop_inst, 1, 0, 1, 2);
        add_commit(1, nop_inst, 2);
        add_row(1, k_end, nop_inst, 1, 0, 1, -1);
        // 2 markers while the report waits on a slow ack
        add_commit(2, seg_start_inst, 1);
        add_commit(2, nop_inst, 3);
        add_row(2, k_commit, seg_stop_inst, 1, 0, 1, 20);
        add_commit(2, seg_start_inst, 1);
        add_commit(2, nop_inst, 1);
        add_commit(2, seg_stop_inst, 1);
        add_row(2, k_sync, nop_inst, 1, 0, 1, -1);
        add_commit(2, seg_start_inst, 1);
        add_commit(2, nop_inst, 4);
        add_row(2, k_commit, seg_stop_inst, 1, 0, 1, 1);
        add_row(2, k_end, nop_inst, 1, 0, 1, -1);
        // 3 order gap and pc break
        add_commit(3, nop_inst, 2);
        add_row(3, k_commit, nop_inst, 2, 0, 1, -1);
        add_commit(3, nop_inst, 2);
        add_row(3, k_commit, nop_inst, 1, 1, 1, -1);
        add_commit(3, nop_inst, 3);
        add_row(3, k_end, nop_inst, 1, 0, 1, -1);
        // 4 mismatch and warning saturation
        add_commit(4, nop_inst, 1);
        add_commit(4, mismatch_inst, 1);
        add_commit(4, warn_inst, 260);
        add_row(4, k_end, nop_inst, 1, 0, 1, -1);
        // 5 to 7 the three halt causes followed by commits that must be ignored
        add_commit(5, nop_inst, 2);
        add_commit(5, halt_inst, 1);
        add_commit(5, mismatch_inst, 1);
        add_commit(5, warn_inst, 1);
        add_row(5, k_commit, nop_inst, 2, 1, 1, -1);
        add_commit(5, seg_start_inst, 1);
        add_commit(5, seg_stop_inst, 1);
        add_row(5, k_end, nop_inst, 1, 0, 1, -1);
        add_commit(6, seg_start_inst, 1);
        add_commit(6, nop_inst, 2);
        add_row(6, k_commit, nop_inst, 1, 2, 1, -1);
        add_commit(6, seg_stop_inst, 1);
        add_commit(6, mismatch_inst, 1);
        add_row(6, k_end, nop_inst, 1, 0, 1, -1);
        add_commit(7, nop_inst, 1);
        add_commit(7, branch_loop_inst, 1);
        add_commit(7, warn_inst, 1);
        add_row(7, k_commit, nop_inst, 1, 1, 1, -1);
        add_row(7, k_end, nop_inst, 1, 0, 1, -1);
    endtask

    task automatic apply_reset;
        @(posedge itf);
        reset <= 1'b1;
        commit_valid <= 1'b0;
        report_ack <= 1'b0;
        repeat (5) @(posedge itf);
        reset <= 1'b0;
        next_order = '0;
        next_pc = 32'h0000_1000;
    endtask

    task automatic drive_commit(input row_t r);
        int gap;
        order_t cur_order;
        addr_t rdata;
        take_bits(2, gap);
        repeat (gap) begin
            @(posedge itf);
            commit_valid <= 1'b0;
        end
        cur_order = next_order + order_t'(r.ostep - 1);
        rdata = (r.pcrel == 1) ? next_pc + 32'd8 : next_pc;
        next_order = cur_order + 1'b1;
        next_pc = (r.pcrel == 2) ? rdata : rdata + 32'd4;
        @(posedge itf);
        check_id <= r.id;
        commit_valid <= 1'b1;
        commit_inst <= r.inst;
        commit_order <= cur_order;
        commit_pc_rdata <= rdata;
        commit_pc_wdata <= next_pc;
    endtask

    // four-phase responder for one expected report
    task automatic ack_report(input int base_delay);
        int extra;
        int waited;
        take_bits(3, extra);
        waited = 0;
        do begin
            @(negedge itf);
            waited++;
        end while (!report_req && waited < 40);
        if (!report_req) begin
            $display("timeout: no report request after a stop marker");
            tb_errors++;
        end else begin
            repeat (base_delay + extra) @(posedge itf);
            report_ack <= 1'b1;
            waited = 0;
            do begin
                @(negedge itf);
                waited++;
            end while (report_req && waited < 40);
            if (report_req) begin
                $display("timeout: report request still high after ack");
                tb_errors++;
            end
            @(posedge itf);
            report_ack <= 1'b0;
        end
        acks_open--;
    endtask

    task automatic wait_idle;
        int waited;
        waited = 0;
        do begin
            @(negedge itf);
            waited++;
        end while ((acks_open != 0 || report_req || report_ack) && waited < 200);
        if (acks_open != 0 || report_req || report_ack) begin
            $display("timeout: report handshake never returned to idle");
            tb_errors++;
        end
        repeat (4) @(posedge itf);
    endtask

    task automatic run_row(input row_t r);
        if (r.kind == k_commit) begin
            for (int n = 0; n < r.rep; n++) begin
                drive_commit(r);
            end
            if (r.ack_delay >= 0) begin
                acks_open++;
                fork
                    automatic int d = r.ack_delay;
                    ack_report(d);
                join_none
            end
        end else begin
            @(posedge itf);
            commit_valid <= 1'b0;
            wait_idle();
            if (r.kind == k_end) begin
                check_id <= r.id;
                check_stb <= 1'b1;
                @(posedge itf);
                check_stb <= 1'b0;
                apply_reset();
            end
        end
    endtask

    initial begin
        itf = 1'b0;
        reset = 1'b1;
        commit_valid = 1'b0;
        commit_order = '0;
        commit_inst = nop_inst;
        commit_pc_rdata = '0;
        commit_pc_wdata = '0;
        report_ack = 1'b0;
        check_stb = 1'b0;
        check_id = 0;
        lfsr_state = 8'd14;
        tb_errors = 0;
        acks_open = 0;
        build_table();
        apply_reset();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("tests %0d, errors %0d", sb_tests, sb_errors + tb_errors);
        if (sb_errors == 0 && tb_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #5_000_000;
        $display("timeout: simulation ran too long");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== retire_monitor_top.f ====
source/retire_mon_pkg.sv
source/monitor_ifs.sv
source/commit_classifier.sv
source/commit_checker.sv
source/segment_fsm.sv
source/segment_counters.sv
source/report_port.sv
source/retire_monitor_top.sv
verif/retire_monitor_properties.sv
verif/retire_monitor_scoreboard.sv
verif/retire_monitor_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = retire_monitor_tb
FILELIST = retire_monitor_top.f
OBJDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
